/* filelist.f */
+incdir+logic
logic/glue_csr_pkg.sv
logic/glue_mem_pkg.sv
logic/csr_bank.sv
logic/addr_xlate.sv
logic/mem_profiler.sv
logic/zynq_glue_top.sv
verif/zynq_glue_tb.sv

/* logic/addr_xlate.sv */
`timescale 1ns/100ps
`default_nettype none

`include "glue_cfg.svh"

module addr_xlate (
   input  wire                              aclk_i,
   input  wire                              rst_n_i,
   input  wire glue_mem_pkg::host_req_s     host_req_i,
   input  wire glue_mem_pkg::core_req_s     dram_req_i,
   input  wire                              dram_init_i,
   input  wire [`GLUE_ADDR_W-1:0]           dram_base_i,
   output glue_mem_pkg::core_req_s          core_req_o,
   output glue_mem_pkg::ps_req_s            ps_req_o
);

   import glue_mem_pkg::*;

   logic [`GLUE_ADDR_W-1:0] host_xlat_w;
   logic [`GLUE_ADDR_W-1:0] dram_off_w;
   logic                    dram_err_w;
   core_req_s               core_q;
   ps_req_s                 ps_q;

   ////////////////////////////////////////
   // host window
   ////////////////////////////////////////

   // host 0x0xxx_xxxx -> core dram 0x8xxx_xxxx
   // host 0x2xxx_xxxx -> core local 0x0xxx_xxxx, tiles 0 to 15
   assign host_xlat_w = {~host_req_i.addr[29], 3'b000, host_req_i.addr[27:0]};

   always_ff @(posedge aclk_i) begin
      if (!rst_n_i) begin
         core_q.v <= 1'b0;
      end else begin
         core_q.v <= host_req_i.v;
      end
      core_q.wr   <= host_req_i.wr;
      core_q.addr <= host_xlat_w;
   end

   assign core_req_o = core_q;

   ////////////////////////////////////////
   // core dram to PS dram
   ////////////////////////////////////////

   // strip the core dram base, leaving an offset into the allocation
   assign dram_off_w = dram_req_i.addr ^ `GLUE_DRAM_BASE;

   assign dram_err_w = ~dram_init_i
                     | ~dram_req_i.addr.dram.is_dram
                     | (dram_off_w >= `GLUE_DRAM_LIMIT);

   always_ff @(posedge aclk_i) begin
      if (!rst_n_i) begin
         ps_q.v <= 1'b0;
      end else begin
         ps_q.v <= dram_req_i.v;
      end
      ps_q.wr   <= dram_req_i.wr;
      ps_q.addr <= dram_off_w + dram_base_i;
      ps_q.err  <= dram_err_w;
   end

   assign ps_req_o = ps_q;

   // bit 28 has no window behind it on the GP port
   a_host_bit28: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i)
      host_req_i.v |-> !host_req_i.addr[28]
   ) else $error("addr_xlate: host address %h outside both windows", host_req_i.addr);

   // the local window only reaches the first 16 tiles
   a_local_tile: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i)
      (core_req_o.v && !core_req_o.addr.lcl.is_dram) |-> (core_req_o.addr.lcl.tile < 7'd16)
   ) else $error("addr_xlate: local request to tile %0d", core_req_o.addr.lcl.tile);

endmodule

`default_nettype wire

/* logic/csr_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "glue_cfg.svh"

module csr_bank (
   input  wire                              aclk_i,
   input  wire                              rst_n_i,
   input  wire glue_csr_pkg::csr_wr_s       csr_wr_i,
   input  wire glue_csr_pkg::csr_rd_s       csr_rd_i,
   input  wire [2*`GLUE_DATA_W-1:0]         minstret_i,
   input  wire [`GLUE_PROFILE_BITS-1:0]     profile_i,
   output glue_csr_pkg::csr_rdata_s         csr_rdata_o,
   output logic                             sys_resetn_o,
   output logic                             core_reset_o,
   output logic                             dram_init_o,
   output logic [`GLUE_ADDR_W-1:0]          dram_base_o
);

   import glue_csr_pkg::*;

   logic [`GLUE_NUM_CTRL-1:0][`GLUE_DATA_W-1:0] ctrl_q;
   logic [`GLUE_NUM_STAT-1:0][`GLUE_DATA_W-1:0] stat_w;
   csr_rdata_s                                  rdata_q;

   ////////////////////////////////////////
   // control registers
   ////////////////////////////////////////

   // core stays held until the host releases it
   always_ff @(posedge aclk_i) begin
      if (!rst_n_i) begin
         ctrl_q                 <= '0;
         ctrl_q[CTRL_CORE_HOLD] <= `GLUE_DATA_W'(1);
      end else if (csr_wr_i.v) begin
         ctrl_q[csr_wr_i.idx] <= csr_wr_i.data;
      end
   end

   // sys_resetn is active low, written as a plain level
   assign sys_resetn_o = ctrl_q[CTRL_SYS_RESET][0];

   assign core_reset_o = ~rst_n_i | ctrl_q[CTRL_CORE_HOLD][0];

   assign dram_init_o = ctrl_q[CTRL_DRAM_INIT][0];
   assign dram_base_o = ctrl_q[CTRL_DRAM_BASE];

   ////////////////////////////////////////
   // status read-back
   ////////////////////////////////////////

   // profiler words go out lowest bits first
   assign stat_w[STAT_MINSTRET_LO] = minstret_i[0 +: `GLUE_DATA_W];
   assign stat_w[STAT_MINSTRET_HI] = minstret_i[`GLUE_DATA_W +: `GLUE_DATA_W];
   assign stat_w[STAT_PROFILE_0]   = profile_i[0*`GLUE_DATA_W +: `GLUE_DATA_W];
   assign stat_w[STAT_PROFILE_1]   = profile_i[1*`GLUE_DATA_W +: `GLUE_DATA_W];
   assign stat_w[STAT_PROFILE_2]   = profile_i[2*`GLUE_DATA_W +: `GLUE_DATA_W];
   assign stat_w[STAT_PROFILE_3]   = profile_i[3*`GLUE_DATA_W +: `GLUE_DATA_W];

   // one read per cycle, data lands on the next edge
   always_ff @(posedge aclk_i) begin
      if (!rst_n_i) begin
         rdata_q.v <= 1'b0;
      end else begin
         rdata_q.v <= csr_rd_i.v;
      end
      if (csr_rd_i.idx < `GLUE_NUM_STAT) begin
         rdata_q.data <= stat_w[csr_rd_i.idx];
      end else begin
         rdata_q.data <= '0;
      end
   end

   assign csr_rdata_o = rdata_q;

   // host may only address the six status words
   a_rd_idx_range: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i)
      csr_rd_i.v |-> (csr_rd_i.idx < `GLUE_NUM_STAT)
   ) else $error("csr_bank: status read index %0d out of range", csr_rd_i.idx);

endmodule

`default_nettype wire

/* logic/glue_cfg.svh */
`ifndef GLUE_CFG_SVH
`define GLUE_CFG_SVH

////////////////////////////////////////
// host register bus
////////////////////////////////////////
`define GLUE_DATA_W        32
`define GLUE_NUM_CTRL      4
`define GLUE_NUM_STAT      6

////////////////////////////////////////
// address spaces
////////////////////////////////////////
`define GLUE_ADDR_W        32
// GP port drops the top two address bits
`define GLUE_HOST_ADDR_W   30
`define GLUE_DRAM_BASE     32'h8000_0000
// 256 MB usable by the core
`define GLUE_DRAM_LIMIT    32'h1000_0000

// profiler geometry, one bit per 8 MB region
`define GLUE_REGION_W      7
`define GLUE_REGION_LSB    23
`define GLUE_PROFILE_BITS  128

`endif

/* logic/glue_csr_pkg.sv */
`default_nettype none

`include "glue_cfg.svh"

package glue_csr_pkg;

   ////////////////////////////////////////
   // register map
   ////////////////////////////////////////

   // control words written by the host
   typedef enum logic [1:0] {
      CTRL_SYS_RESET = 2'd0,
      CTRL_CORE_HOLD = 2'd1,
      CTRL_DRAM_INIT = 2'd2,
      CTRL_DRAM_BASE = 2'd3
   } ctrl_idx_e;

   // status words read back by the host
   typedef enum logic [2:0] {
      STAT_MINSTRET_LO = 3'd0,
      STAT_MINSTRET_HI = 3'd1,
      STAT_PROFILE_0   = 3'd2,
      STAT_PROFILE_1   = 3'd3,
      STAT_PROFILE_2   = 3'd4,
      STAT_PROFILE_3   = 3'd5
   } stat_idx_e;

   ////////////////////////////////////////
   // host register bus
   ////////////////////////////////////////

   typedef struct packed {
      logic                    v;
      ctrl_idx_e               idx;
      logic [`GLUE_DATA_W-1:0] data;
   } csr_wr_s;

   typedef struct packed {
      logic      v;
      stat_idx_e idx;
   } csr_rd_s;

   typedef struct packed {
      logic                    v;
      logic [`GLUE_DATA_W-1:0] data;
   } csr_rdata_s;

endpackage

`default_nettype wire

/* logic/glue_mem_pkg.sv */
`default_nettype none

`include "glue_cfg.svh"

package glue_mem_pkg;

   ////////////////////////////////////////
   // core physical address
   ////////////////////////////////////////

   // cached dram space, bit 31 set
   typedef struct packed {
      logic                        is_dram;
      logic                        rsvd;
      logic [`GLUE_REGION_W-1:0]   region;
      logic [`GLUE_REGION_LSB-1:0] offset;
   } dram_view_s;

   // local space: tile, device, then a 1 MB window
   typedef struct packed {
      logic        is_dram;
      logic [6:0]  tile;
      logic [3:0]  device;
      logic [19:0] offset;
   } local_view_s;

   typedef union packed {
      dram_view_s  dram;
      local_view_s lcl;
   } core_addr_u;

   ////////////////////////////////////////
   // requests
   ////////////////////////////////////////

   // from the host GP port
   typedef struct packed {
      logic                         v;
      logic                         wr;
      logic [`GLUE_HOST_ADDR_W-1:0] addr;
   } host_req_s;

   // in core physical space
   typedef struct packed {
      logic       v;
      logic       wr;
      core_addr_u addr;
   } core_req_s;

   // toward PS DRAM
   typedef struct packed {
      logic                    v;
      logic                    wr;
      logic [`GLUE_ADDR_W-1:0] addr;
      logic                    err;
   } ps_req_s;

endpackage

`default_nettype wire

/* logic/mem_profiler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "glue_cfg.svh"

module mem_profiler (
   input  wire                              aclk_i,
   input  wire                              rst_n_i,
   input  wire                              core_reset_i,
   input  wire glue_mem_pkg::core_req_s     dram_req_i,
   output logic [`GLUE_PROFILE_BITS-1:0]    profile_o
);

   import glue_mem_pkg::*;

   logic [`GLUE_PROFILE_BITS-1:0] prof_q;
   logic                          hit_w;

   // local-space traffic says nothing about dram footprint
   assign hit_w = dram_req_i.v & dram_req_i.addr.dram.is_dram;

   ////////////////////////////////////////
   // sticky region bitmap
   ////////////////////////////////////////

   always_ff @(posedge aclk_i) begin
      if (!rst_n_i || core_reset_i) begin
         prof_q <= '0;
      end else if (hit_w) begin
         prof_q[dram_req_i.addr.dram.region] <= 1'b1;
      end
   end

   assign profile_o = prof_q;

   // bits only accumulate while the core runs
   a_sticky: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i || core_reset_i)
      !core_reset_i |=> ((~prof_q & $past(prof_q)) == '0)
   ) else $error("mem_profiler: region bit cleared outside reset");

endmodule

`default_nettype wire

/* logic/zynq_glue_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "glue_cfg.svh"

module zynq_glue_top (
   input  wire                              aclk_i,
   input  wire                              rst_n_i,
   // host register bus
   input  wire glue_csr_pkg::csr_wr_s       csr_wr_i,
   input  wire glue_csr_pkg::csr_rd_s       csr_rd_i,
   output glue_csr_pkg::csr_rdata_s         csr_rdata_o,
   // core side
   input  wire [2*`GLUE_DATA_W-1:0]         minstret_i,
   output logic                             sys_resetn_o,
   output logic                             core_reset_o,
   // address paths
   input  wire glue_mem_pkg::host_req_s     host_req_i,
   input  wire glue_mem_pkg::core_req_s     dram_req_i,
   output glue_mem_pkg::core_req_s          core_req_o,
   output glue_mem_pkg::ps_req_s            ps_req_o
);

   logic                          dram_init_w;
   logic [`GLUE_ADDR_W-1:0]       dram_base_w;
   logic [`GLUE_PROFILE_BITS-1:0] profile_w;

   csr_bank u_csr_bank (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .csr_wr_i     (csr_wr_i),
      .csr_rd_i     (csr_rd_i),
      .minstret_i   (minstret_i),
      .profile_i    (profile_w),
      .csr_rdata_o  (csr_rdata_o),
      .sys_resetn_o (sys_resetn_o),
      .core_reset_o (core_reset_o),
      .dram_init_o  (dram_init_w),
      .dram_base_o  (dram_base_w)
   );

   addr_xlate u_addr_xlate (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .host_req_i  (host_req_i),
      .dram_req_i  (dram_req_i),
      .dram_init_i (dram_init_w),
      .dram_base_i (dram_base_w),
      .core_req_o  (core_req_o),
      .ps_req_o    (ps_req_o)
   );

   // profiler watches the raw core dram requests
   mem_profiler u_mem_profiler (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .core_reset_i (core_reset_o),
      .dram_req_i   (dram_req_i),
      .profile_o    (profile_w)
   );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the glue testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module zynq_glue_tb -f filelist.f -o zynq_glue_sim \
   && ./obj_dir/zynq_glue_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: no result line in sim.log"; exit 1; }
echo "PASS"
exit 0

/* verif/zynq_glue_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "glue_cfg.svh"

module zynq_glue_tb;

   import glue_csr_pkg::*;
   import glue_mem_pkg::*;

   localparam int TIMEOUT_CYCLES = 20;

   logic                          aclk;
   logic                          rst_n;
   csr_wr_s                       csr_wr;
   csr_rd_s                       csr_rd;
   csr_rdata_s                    csr_rdata;
   logic [2*`GLUE_DATA_W-1:0]     minstret;
   logic                          sys_resetn;
   logic                          core_reset;
   host_req_s                     host_req;
   core_req_s                     dram_req;
   core_req_s                     core_req;
   ps_req_s                       ps_req;

   integer                        seed;
   integer                        errors;
   integer                        checks;
   // what the host has programmed so far
   logic [`GLUE_ADDR_W-1:0]       base_shadow;
   logic                          init_shadow;
   logic [`GLUE_PROFILE_BITS-1:0] prof_exp;

   zynq_glue_top uut (
      .aclk_i       (aclk),
      .rst_n_i      (rst_n),
      .csr_wr_i     (csr_wr),
      .csr_rd_i     (csr_rd),
      .csr_rdata_o  (csr_rdata),
      .minstret_i   (minstret),
      .sys_resetn_o (sys_resetn),
      .core_reset_o (core_reset),
      .host_req_i   (host_req),
      .dram_req_i   (dram_req),
      .core_req_o   (core_req),
      .ps_req_o     (ps_req)
   );

   always #20 aclk = ~aclk;

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task check_word(input string what, input logic [`GLUE_DATA_W-1:0] got,
                   input logic [`GLUE_DATA_W-1:0] exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task check_core_req(input string what, input core_req_s got, input core_req_s exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("Error at %0d ns: %s is v %b wr %b addr %h, expected v %b wr %b addr %h",
                  $time, what, got.v, got.wr, got.addr, exp.v, exp.wr, exp.addr);
      end
   endtask

   task check_ps_req(input string what, input ps_req_s got, input ps_req_s exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("Error at %0d ns: %s is wr %b addr %h err %b, expected wr %b addr %h err %b",
                  $time, what, got.wr, got.addr, got.err, exp.wr, exp.addr, exp.err);
      end
   endtask

   task report_timeout(input string what);
      errors = errors + 1;
      $display("Timeout: %s never went valid within %0d cycles", what, TIMEOUT_CYCLES);
   endtask

   ////////////////////////////////////////
   // bus drivers
   ////////////////////////////////////////

   // returns just after the edge that takes the write
   task write_ctrl(input ctrl_idx_e idx, input logic [`GLUE_DATA_W-1:0] data);
      @(posedge aclk);
      csr_wr <= {1'b1, idx, data};
      @(posedge aclk);
      csr_wr.v <= 1'b0;
      #1;
   endtask

   task read_stat(input stat_idx_e idx, output logic [`GLUE_DATA_W-1:0] data);
      int cyc;
      data = '0;
      @(posedge aclk);
      csr_rd <= {1'b1, idx};
      @(posedge aclk);
      csr_rd.v <= 1'b0;
      #1;
      cyc = 1;
      while (!csr_rdata.v && cyc < TIMEOUT_CYCLES) begin
         @(posedge aclk);
         #1;
         cyc = cyc + 1;
      end
      if (csr_rdata.v) begin
         check_word("status read latency", cyc, 1);
         data = csr_rdata.data;
      end else begin
         report_timeout("csr_rdata_o");
      end
   endtask

   task host_request(input logic [`GLUE_HOST_ADDR_W-1:0] addr, input logic wr);
      core_req_s exp;
      int        cyc;
      exp.v  = 1'b1;
      exp.wr = wr;
      // host 0x2xxx_xxxx lands in core local space at 0x0xxx_xxxx
      // host 0x0xxx_xxxx lands in core dram at 0x8xxx_xxxx
      if (addr[29]) begin
         exp.addr = {2'b00, addr} - 32'h2000_0000;
      end else begin
         exp.addr = {2'b00, addr} + 32'h8000_0000;
      end
      @(posedge aclk);
      host_req <= {1'b1, wr, addr};
      @(posedge aclk);
      host_req.v <= 1'b0;
      #1;
      cyc = 1;
      while (!core_req.v && cyc < TIMEOUT_CYCLES) begin
         @(posedge aclk);
         #1;
         cyc = cyc + 1;
      end
      if (core_req.v) begin
         check_word("host path latency", cyc, 1);
         check_core_req("core_req_o", core_req, exp);
      end else begin
         report_timeout("core_req_o");
      end
   endtask

   function automatic ps_req_s expected_ps_req(input logic [`GLUE_ADDR_W-1:0] addr,
                                               input logic wr);
      ps_req_s                 exp;
      logic [`GLUE_ADDR_W-1:0] off;
      off      = {~addr[31], addr[30:0]};
      exp.v    = 1'b1;
      exp.wr   = wr;
      exp.addr = off + base_shadow;
      exp.err  = !init_shadow || !addr[31] || (off >= `GLUE_DRAM_LIMIT);
      return exp;
   endfunction

   task dram_request(input logic [`GLUE_ADDR_W-1:0] addr, input logic wr);
      ps_req_s exp;
      int      cyc;
      exp = expected_ps_req(addr, wr);
      @(posedge aclk);
      dram_req <= {1'b1, wr, addr};
      @(posedge aclk);
      dram_req.v <= 1'b0;
      #1;
      cyc = 1;
      while (!ps_req.v && cyc < TIMEOUT_CYCLES) begin
         @(posedge aclk);
         #1;
         cyc = cyc + 1;
      end
      if (ps_req.v) begin
         check_word("dram path latency", cyc, 1);
         check_ps_req("ps_req_o", ps_req, exp);
      end else begin
         report_timeout("ps_req_o");
      end
   endtask

   task check_profile(input logic [`GLUE_PROFILE_BITS-1:0] exp);
      logic [`GLUE_DATA_W-1:0] word;
      read_stat(STAT_PROFILE_0, word);
      check_word("profile word 0", word, exp[31:0]);
      read_stat(STAT_PROFILE_1, word);
      check_word("profile word 1", word, exp[63:32]);
      read_stat(STAT_PROFILE_2, word);
      check_word("profile word 2", word, exp[95:64]);
      read_stat(STAT_PROFILE_3, word);
      check_word("profile word 3", word, exp[127:96]);
   endtask

   // one request into an 8 MB region at a random offset
   task touch_region(input logic [6:0] region);
      logic [31:0] r;
      r = $random(seed);
      dram_request({1'b1, 1'b0, region, r[22:0]}, r[31]);
      prof_exp[region] = 1'b1;
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task test_reset_state;
      @(posedge aclk);
      #1;
      check_word("sys_resetn_o after reset", {31'd0, sys_resetn}, 32'd0);
      check_word("core_reset_o after reset", {31'd0, core_reset}, 32'd1);
      check_word("ps_req_o valid after reset", {31'd0, ps_req.v}, 32'd0);
      check_profile('0);
   endtask

   task test_ctrl_writes;
      write_ctrl(CTRL_SYS_RESET, 32'd1);
      check_word("sys_resetn_o after write", {31'd0, sys_resetn}, 32'd1);
      write_ctrl(CTRL_CORE_HOLD, 32'd0);
      check_word("core_reset_o after release", {31'd0, core_reset}, 32'd0);
   endtask

   task test_status_readback;
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] word;
      lo = $random(seed);
      hi = $random(seed);
      @(posedge aclk);
      minstret <= {hi, lo};
      read_stat(STAT_MINSTRET_LO, word);
      check_word("minstret low", word, lo);
      read_stat(STAT_MINSTRET_HI, word);
      check_word("minstret high", word, hi);
   endtask

   task test_host_window;
      logic [31:0] r;
      for (int i = 0; i < 8; i = i + 1) begin
         r = $random(seed);
         r[28] = 1'b0;
         // alternate between the dram and local windows
         r[29] = i[0];
         host_request(r[29:0], r[31]);
      end
   endtask

   task test_dram_xlate;
      logic [31:0] r;
      base_shadow = $random(seed);
      write_ctrl(CTRL_DRAM_BASE, base_shadow);
      init_shadow = 1'b1;
      write_ctrl(CTRL_DRAM_INIT, 32'd1);
      for (int i = 0; i < 6; i = i + 1) begin
         r = $random(seed);
         dram_request({4'h8, r[27:0]}, r[31]);
      end
      // past the 256 MB allocation
      r = $random(seed);
      dram_request({4'h9, r[27:0]}, r[31]);
      // local space never reaches PS dram
      r = $random(seed);
      dram_request({1'b0, r[30:0]}, r[31]);
      init_shadow = 1'b0;
      write_ctrl(CTRL_DRAM_INIT, 32'd0);
      r = $random(seed);
      dram_request({4'h8, r[27:0]}, r[31]);
      init_shadow = 1'b1;
      write_ctrl(CTRL_DRAM_INIT, 32'd1);
   endtask

   task test_profiler;
      // earlier traffic is wiped by a core hold pulse
      write_ctrl(CTRL_CORE_HOLD, 32'd1);
      write_ctrl(CTRL_CORE_HOLD, 32'd0);
      prof_exp = '0;
      touch_region(7'd0);
      touch_region(7'd5);
      touch_region(7'd31);
      touch_region(7'd32);
      touch_region(7'd63);
      touch_region(7'd64);
      touch_region(7'd100);
      touch_region(7'd127);
      // local request whose region field would be 1
      dram_request(32'h0080_0000, 1'b0);
      check_profile(prof_exp);
      write_ctrl(CTRL_CORE_HOLD, 32'd1);
      write_ctrl(CTRL_CORE_HOLD, 32'd0);
      check_profile('0);
   endtask

   initial begin
      seed        = 32'hdb6a_a785;
      errors      = 0;
      checks      = 0;
      base_shadow = '0;
      init_shadow = 1'b0;
      prof_exp    = '0;
      aclk        = 1'b0;
      rst_n       = 1'b0;
      csr_wr      = '0;
      csr_rd      = '0;
      minstret    = '0;
      host_req    = '0;
      dram_req    = '0;
      repeat (10) @(posedge aclk);
      rst_n <= 1'b1;

      test_reset_state();
      test_ctrl_writes();
      test_status_readback();
      test_host_window();
      test_dram_xlate();
      test_profiler();

      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
